/* host_to_card_dma.f */
rtl/dma_pkg.sv
rtl/read_requester.sv
rtl/reorder_buffer.sv
rtl/stream_fifo.sv
rtl/host_to_card_dma.sv
tests/tb_host_to_card_dma.sv

/* rtl/dma_pkg.sv */
package dma_pkg;

   localparam int WORD_BITS   = 64;
   localparam int BLOCK_WORDS = 64;  // 512-byte block
   localparam int TAG_COUNT   = 8;
   localparam int PT_ENTRIES  = 32;
   localparam int MAX_AHEAD   = 6;
   localparam int FIFO_DEPTH  = 16;

   // pio register map
   localparam logic [12:0] PIO_PT_BASE   = 13'h040;  // 32 page table entries
   localparam logic [12:0] PIO_STOP_ADDR = 13'h006;
   localparam logic [12:0] PIO_INT_ADDR  = 13'h007;

   typedef logic [WORD_BITS-1:0] word_t;
   typedef logic [7:0]           tag_t;
   typedef logic [5:0]           word_index_t;
   typedef logic [16:0]          block_count_t;  // in 512-byte units
   typedef logic [12:0]          pio_addr_t;
   typedef logic [63:0]          host_addr_t;

   typedef struct packed {
      logic      valid;
      pio_addr_t addr;
      word_t     data;
   } pio_write_t;

   typedef struct packed {
      host_addr_t addr;
      tag_t       tag;
   } read_req_t;

   typedef struct packed {
      logic        valid;
      tag_t        tag;
      word_index_t index;
      word_t       data;
   } completion_t;

endpackage

/* rtl/host_to_card_dma.sv */
`timescale 1ns/1ps

module host_to_card_dma import dma_pkg::*;
(
   input  logic        i_clock,
   input  logic        i_reset,
   input  pio_write_t  i_pio,
   input  logic        i_rr_ready,
   input  completion_t i_completion,
   input  logic        i_fifo_read,
   output logic        o_rr_valid,
   output read_req_t   o_rr,
   output host_addr_t  o_status,
   output logic [1:0]  o_interrupt,
   output word_t       o_fifo_data,
   output logic        o_fifo_valid
);

   block_count_t read_block;
   block_count_t stop_mark;
   block_count_t int_mark;
   logic         push;
   word_t        push_data;
   logic         fifo_ready;

   read_requester u_requester
   (
      .i_clock      (i_clock),
      .i_reset      (i_reset),
      .i_pio        (i_pio),
      .i_rr_ready   (i_rr_ready),
      .i_read_block (read_block),
      .o_rr_valid   (o_rr_valid),
      .o_rr         (o_rr),
      .o_stop_mark  (stop_mark),
      .o_int_mark   (int_mark)
   );

   reorder_buffer u_reorder
   (
      .i_clock      (i_clock),
      .i_reset      (i_reset),
      .i_completion (i_completion),
      .i_fifo_ready (fifo_ready),
      .i_stop_mark  (stop_mark),
      .i_int_mark   (int_mark),
      .o_push       (push),
      .o_push_data  (push_data),
      .o_read_block (read_block),
      .o_status     (o_status),
      .o_interrupt  (o_interrupt)
   );

   stream_fifo u_fifo
   (
      .i_clock     (i_clock),
      .i_reset     (i_reset),
      .i_push      (push),
      .i_push_data (push_data),
      .i_read      (i_fifo_read),
      .o_ready     (fifo_ready),
      .o_data      (o_fifo_data),
      .o_valid     (o_fifo_valid)
   );

endmodule

/* rtl/read_requester.sv */
`timescale 1ns/1ps

module read_requester import dma_pkg::*;
(
   input  logic         i_clock,
   input  logic         i_reset,
   input  pio_write_t   i_pio,
   input  logic         i_rr_ready,
   input  block_count_t i_read_block,
   output logic         o_rr_valid,
   output read_req_t    o_rr,
   output block_count_t o_stop_mark,
   output block_count_t o_int_mark
);

   logic [42:0]  page_table [PT_ENTRIES];
   logic [42:0]  page_q;            // entry for the current request
   block_count_t p_request;
   block_count_t p_request_next;
   block_count_t ahead;
   logic         accept;
   logic         pt_write;
   logic         stop_write;
   logic         int_write;

   assign pt_write   = i_pio.valid && (i_pio.addr[12:5] == PIO_PT_BASE[12:5]);
   assign stop_write = i_pio.valid && (i_pio.addr == PIO_STOP_ADDR);
   assign int_write  = i_pio.valid && (i_pio.addr == PIO_INT_ADDR);

   // blocks requested but not yet drained by the reorder buffer
   assign ahead = p_request - i_read_block;

   assign o_rr_valid = (p_request != o_stop_mark) && (ahead < block_count_t'(MAX_AHEAD));
   assign accept     = o_rr_valid && i_rr_ready;

   assign p_request_next = p_request + block_count_t'(accept);

   assign o_rr.addr = {page_q, p_request[11:0], 9'd0};
   assign o_rr.tag  = {5'd0, p_request[2:0]};  // r mod 8

   // looking up the next pointer keeps page_q aligned with p_request
   always_ff @(posedge i_clock)
   begin
      if (pt_write)
         page_table[i_pio.addr[4:0]] <= i_pio.data[63:21];
      page_q <= page_table[p_request_next[16:12]];
   end

   always_ff @(posedge i_clock)
   begin
      if (i_reset)
      begin
         p_request   <= '0;
         o_stop_mark <= '0;
         o_int_mark  <= '0;
      end
      else
      begin
         p_request <= p_request_next;
         if (stop_write)
            o_stop_mark <= i_pio.data[25:9];
         if (int_write)
            o_int_mark <= i_pio.data[25:9];
      end
   end

   // a stalled request must be held until the host takes it
   held_request: assert property (@(posedge i_clock) disable iff (i_reset)
      o_rr_valid && !i_rr_ready |=> o_rr_valid && $stable(o_rr));

endmodule

/* rtl/reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer import dma_pkg::*;
(
   input  logic         i_clock,
   input  logic         i_reset,
   input  completion_t  i_completion,
   input  logic         i_fifo_ready,
   input  block_count_t i_stop_mark,
   input  block_count_t i_int_mark,
   output logic         o_push,
   output word_t        o_push_data,
   output block_count_t o_read_block,
   output host_addr_t   o_status,
   output logic [1:0]   o_interrupt
);

   word_t                ram [TAG_COUNT*BLOCK_WORDS];
   word_t                ram_q;
   logic [TAG_COUNT-1:0] filled;
   logic [2:0]           wr_slot;
   logic                 wr_en;
   logic                 wr_last;
   block_count_t         p_write;      // blocks complete in order
   block_count_t         p_read_block;
   word_index_t          p_read_word;
   logic                 advance;
   logic                 drain;
   logic                 drain_q;

   assign wr_slot = i_completion.tag[2:0];
   assign wr_en   = i_completion.valid && (i_completion.tag[7:3] == 5'd0);  // tags 0..7 only
   assign wr_last = wr_en && (i_completion.index == word_index_t'(BLOCK_WORDS - 1));

   assign advance = filled[p_write[2:0]];
   assign drain   = (p_read_block != p_write) && i_fifo_ready;

   assign o_read_block = p_read_block;

   // ram read plus push register give two cycles to the fifo
   always_ff @(posedge i_clock)
   begin
      if (wr_en)
         ram[{wr_slot, i_completion.index}] <= i_completion.data;
      ram_q       <= ram[{p_read_block[2:0], p_read_word}];
      o_push_data <= ram_q;
   end

   always_ff @(posedge i_clock)
   begin
      if (i_reset)
         filled <= '0;
      else
      begin
         for (int i = 0; i < TAG_COUNT; i++)
         begin
            if (wr_last && (wr_slot == 3'(i)))
               filled[i] <= 1'b1;
            else if (advance && (p_write[2:0] == 3'(i)))
               filled[i] <= 1'b0;  // consumed by write pointer
         end
      end
   end

   always_ff @(posedge i_clock)
   begin
      if (i_reset)
      begin
         p_write      <= '0;
         p_read_block <= '0;
         p_read_word  <= '0;
         drain_q      <= 1'b0;
         o_push       <= 1'b0;
         o_status     <= '0;
         o_interrupt  <= 2'b00;
      end
      else
      begin
         p_write <= p_write + block_count_t'(advance);
         if (drain)
         begin
            p_read_word <= p_read_word + 1'b1;
            if (p_read_word == word_index_t'(BLOCK_WORDS - 1))
               p_read_block <= p_read_block + 1'b1;
         end
         drain_q     <= drain;
         o_push      <= drain_q;
         o_status    <= host_addr_t'({p_write, 9'd0});  // bytes
         o_interrupt <= {p_write == i_stop_mark, p_write == i_int_mark};
      end
   end

   // requester window must keep a slot free until it is drained
   slot_not_refilled: assert property (@(posedge i_clock) disable iff (i_reset)
      wr_en |-> !filled[wr_slot]);

endmodule

/* rtl/stream_fifo.sv */
`timescale 1ns/1ps

module stream_fifo import dma_pkg::*;
(
   input  logic  i_clock,
   input  logic  i_reset,
   input  logic  i_push,
   input  word_t i_push_data,
   input  logic  i_read,
   output logic  o_ready,
   output word_t o_data,
   output logic  o_valid
);

   word_t                         mem [FIFO_DEPTH];
   logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
   logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
   logic [$clog2(FIFO_DEPTH):0]   count;
   logic                          pop;

   assign pop     = i_read && o_valid;  // reads while empty are dropped
   assign o_valid = (count != '0);
   assign o_data  = mem[rd_ptr];         // head word falls through

   // room for two pushes in flight plus the one being decided
   assign o_ready = (count <= FIFO_DEPTH - 3);

   always_ff @(posedge i_clock)
   begin
      if (i_push)
         mem[wr_ptr] <= i_push_data;
   end

   always_ff @(posedge i_clock)
   begin
      if (i_reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (i_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({i_push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   no_overflow: assert property (@(posedge i_clock) disable iff (i_reset)
      i_push |-> (count != FIFO_DEPTH));

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_host_to_card_dma \
   -f host_to_card_dma.f -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -x "Test OK" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* tests/dma_stim.txt */
// test, page base, stop mark, interrupt mark, block count, tag return order
// all hex; the page base is 2 MB aligned, tag order gives one tag per digit
01 0000000123400000 0000c 00005 0000c 73625140
02 ffff800000000000 00006 00006 00006 01234567
03 0000004a5e600000 00014 00001 00014 52706143
04 8000000000200000 00003 00002 00003 21076543

/* tests/tb_host_to_card_dma.sv */
`timescale 1ns/1ps

module tb_host_to_card_dma import dma_pkg::*;
();

   localparam int TEST_COUNT   = 4;
   localparam int FIELDS       = 6;    // values per stim line
   localparam int STALL_CYCLES = 300;  // card stops reading at test start

   logic         clock = 1'b0;
   logic         reset;
   pio_write_t   pio;
   logic         rr_ready;
   completion_t  completion;
   logic         fifo_read;
   logic         rr_valid;
   read_req_t    rr;
   host_addr_t   status;
   logic [1:0]   interrupt;
   word_t        fifo_data;
   logic         fifo_valid;

   logic [63:0]  stim [TEST_COUNT*FIELDS];
   host_addr_t   req_addr [256];
   tag_t         req_tag [256];
   logic [255:0] returned;
   host_addr_t   base;
   block_count_t stop_mark;
   block_count_t int_mark;
   logic         active;
   logic         seen_int;
   logic [31:0]  rand_state;
   int           test_num;
   int           block_total;
   int           ahead_limit;  // requests expected before the card reads
   int           accepted;
   int           popped;
   int           test_cycles;
   int           cycles;
   int           cycle_limit;
   int           test_errors;
   int           failed_tests;

   host_to_card_dma u_dut
   (
      .i_clock      (clock),
      .i_reset      (reset),
      .i_pio        (pio),
      .i_rr_ready   (rr_ready),
      .i_completion (completion),
      .i_fifo_read  (fifo_read),
      .o_rr_valid   (rr_valid),
      .o_rr         (rr),
      .o_status     (status),
      .o_interrupt  (interrupt),
      .o_fifo_data  (fifo_data),
      .o_fifo_valid (fifo_valid)
   );

   initial
   begin
      forever #10 clock = ~clock;
   end

   function automatic logic [31:0] next_random(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic show_mismatch(input string what, input logic [63:0] expected,
                                input logic [63:0] actual);
      $display("[FAIL] test %0d %s: expected %h, actual %h", test_num, what, expected, actual);
      test_errors++;
   endtask

   task automatic pio_write(input pio_addr_t addr, input word_t data);
      @(negedge clock);
      pio.valid = 1'b1;
      pio.addr  = addr;
      pio.data  = data;
      @(negedge clock);
      pio = '0;
   endtask

   // one whole block, word index in order
   task automatic send_block(input host_addr_t addr, input tag_t tag);
      for (int i = 0; i < BLOCK_WORDS; i++)
      begin
         @(negedge clock);
         completion.valid = 1'b1;
         completion.tag   = tag;
         completion.index = word_index_t'(i);
         completion.data  = addr + (host_addr_t'(i) << 3);
      end
      @(negedge clock);
      completion = '0;
   endtask

   // host side of the request channel and card side of the fifo
   always @(negedge clock)
   begin
      cycles++;
      if (cycles > cycle_limit)
      begin
         $display("timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("Test FAILED");
         $finish;
      end
      else
      begin
         rand_state  = next_random(rand_state);
         test_cycles += int'(active);
         rr_ready    = active && rand_state[20];
         fifo_read   = active && (test_cycles > STALL_CYCLES) && (rand_state[27:26] != 2'b00);
         if (rr_valid && rr_ready)
         begin
            req_addr[accepted] = rr.addr;
            req_tag[accepted]  = rr.tag;
            if (rr.addr != base + (host_addr_t'(accepted) << 9))
               show_mismatch($sformatf("request %0d address", accepted),
                             base + (host_addr_t'(accepted) << 9), rr.addr);
            if (rr.tag != tag_t'(accepted % TAG_COUNT))
               show_mismatch($sformatf("request %0d tag", accepted),
                             64'(accepted % TAG_COUNT), 64'(rr.tag));
            if (accepted >= int'(stop_mark) || accepted > popped / BLOCK_WORDS + MAX_AHEAD)
               show_mismatch($sformatf("request %0d allowed", accepted), 64'd0, 64'd1);
            accepted++;
         end
         if (active && test_cycles == STALL_CYCLES && accepted != ahead_limit)
            show_mismatch("requests during stall", 64'(ahead_limit), 64'(accepted));
         if (fifo_valid && fifo_read)
         begin
            if (popped >= block_total * BLOCK_WORDS
                || fifo_data != base + (host_addr_t'(popped) << 3))
               show_mismatch($sformatf("word %0d", popped),
                             base + (host_addr_t'(popped) << 3), fifo_data);
            popped++;
         end
         if (active && interrupt[1] != (status == (host_addr_t'(stop_mark) << 9)))
            show_mismatch("stop interrupt level",
                          64'(status == (host_addr_t'(stop_mark) << 9)), 64'(interrupt[1]));
         if (interrupt[0] && status == (host_addr_t'(int_mark) << 9))
            seen_int = 1'b1;
      end
   end

   task automatic run_test(input int t);
      int          pos [TAG_COUNT];
      int          pick;
      int          best;
      logic [31:0] perm;
      test_num    = int'(stim[t*FIELDS]);
      base        = stim[t*FIELDS+1];
      stop_mark   = block_count_t'(stim[t*FIELDS+2]);
      int_mark    = block_count_t'(stim[t*FIELDS+3]);
      block_total = int'(stim[t*FIELDS+4]);
      perm        = stim[t*FIELDS+5][31:0];
      ahead_limit = (int'(stop_mark) < MAX_AHEAD) ? int'(stop_mark) : MAX_AHEAD;
      for (int k = 0; k < TAG_COUNT; k++)
         pos[perm[30-4*k -: 3]] = k;  // rank of each tag in the return order
      test_errors = 0;
      accepted    = 0;
      popped      = 0;
      test_cycles = 0;
      seen_int    = 1'b0;
      returned    = '0;
      @(negedge clock);
      reset = 1'b1;
      repeat (10) @(negedge clock);
      reset = 1'b0;
      pio_write(PIO_PT_BASE, base);
      pio_write(PIO_INT_ADDR, host_addr_t'(int_mark) << 9);
      pio_write(PIO_STOP_ADDR, host_addr_t'(stop_mark) << 9);
      @(posedge clock);
      active = 1'b1;
      for (int n = 0; n < block_total; n++)
      begin
         pick = -1;
         while (pick < 0)
         begin
            @(posedge clock);
            best = TAG_COUNT;
            for (int r = 0; r < accepted; r++)
            begin
               if (!returned[r] && pos[req_tag[r][2:0]] < best)
               begin
                  best = pos[req_tag[r][2:0]];
                  pick = r;
               end
            end
         end
         returned[pick] = 1'b1;
         send_block(req_addr[pick], req_tag[pick]);
      end
      while (popped < block_total * BLOCK_WORDS)
         @(posedge clock);
      repeat (4) @(negedge clock);
      if (accepted != int'(stop_mark))
         show_mismatch("requests at stop", 64'(stop_mark), 64'(accepted));
      if (rr_valid)
         show_mismatch("request valid after stop", 64'd0, 64'd1);
      if (status != (host_addr_t'(block_total) << 9))
         show_mismatch("status", host_addr_t'(block_total) << 9, status);
      if (!interrupt[1])
         show_mismatch("stop interrupt", 64'd1, 64'(interrupt[1]));
      if (fifo_valid)
         show_mismatch("words left in fifo", 64'd0, 64'd1);
      if (!seen_int)
         show_mismatch("interrupt at mark", 64'd1, 64'd0);
      pio_write(PIO_INT_ADDR, host_addr_t'(stop_mark + 1'b1) << 9);  // mark moved past count
      repeat (3) @(negedge clock);
      if (interrupt[0])
         show_mismatch("interrupt after new mark", 64'd0, 64'(interrupt[0]));
      @(posedge clock);
      active = 1'b0;
      if (test_errors == 0)
         $display("test %0d: pass, %0d blocks", test_num, block_total);
      else
      begin
         $display("test %0d: fail, %0d errors", test_num, test_errors);
         failed_tests++;
      end
   endtask

   initial
   begin
      reset        = 1'b1;
      pio          = '0;
      rr_ready     = 1'b0;
      completion   = '0;
      fifo_read    = 1'b0;
      active       = 1'b0;
      cycles       = 0;
      failed_tests = 0;
      rand_state   = 32'h8944a290;
      $readmemh("tests/dma_stim.txt", stim);
      cycle_limit = 2000;
      for (int t = 0; t < TEST_COUNT; t++)
         cycle_limit += int'(stim[t*FIELDS+4]) * BLOCK_WORDS * 4;
      for (int t = 0; t < TEST_COUNT; t++)
         run_test(t);
      $display("%0d tests, %0d passed, %0d failed", TEST_COUNT, TEST_COUNT - failed_tests,
               failed_tests);
      if (failed_tests == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule
